// File: design/tlul_pkg.sv
// shared TL-UL widths and SRAM geometry; only Get/PutFullData/PutPartialData are recognized
`default_nettype none

package tlul_pkg;

  // TL-UL bus widths
  localparam int TL_DW  = 32;
  localparam int TL_AW  = 32;
  // bytes per bus word
  localparam int TL_DBW = TL_DW / 8;
  localparam int TL_SZW = 2;
  localparam int TL_AIW = 8;

  // memory geometry, 64-bit words
  localparam int SRAM_DW       = 64;
  localparam int SRAM_AW       = 10;
  localparam int SRAM_WORDS    = 1 << SRAM_AW;
  // address bit 3 and up select the memory word
  localparam int SRAM_BYTE_LSB = 3;
  // one bit picks the upper or lower 32-bit half
  localparam int LANE_W        = 1;

  // requests in flight before a_ready drops
  localparam int OUTSTANDING = 2;
  // 0 forces every write to be a full word
  localparam bit BYTE_ACCESS = 1'b1;

  // request queue entry is {op, error, size, source}
  localparam int REQ_FIFO_W  = 1 + 1 + TL_SZW + TL_AIW;
  // lane queue entry is {mask, lane}
  localparam int LANE_FIFO_W = TL_DBW + LANE_W;
  // response queue holds one masked bus word
  localparam int RSP_FIFO_W  = TL_DW;

  // A channel opcodes
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // adapter view of a queued request
  // errored non-Get requests are treated as writes so they answer with AccessAck
  typedef enum logic [0:0] {
    OpWrite = 1'b0,
    OpRead  = 1'b1
  } req_op_e;

endpackage

`default_nettype wire

// File: design/fifo_sync.sv
// circular FIFO with a count; Pass=1 forwards input when empty, and no reset on storage
`timescale 1ns/1ps
`default_nettype none

module fifo_sync #(
  parameter int Width = 8,
  parameter int Depth = 2,
  parameter bit Pass  = 1'b0
) (
  input  wire logic             clock,
  input  wire logic             rst_n_i,
  input  wire logic             wvalid_i,
  output logic                  wready_o,
  input  wire logic [Width-1:0] wdata_i,
  output logic                  rvalid_o,
  input  wire logic             rready_i,
  output logic      [Width-1:0] rdata_o
);

  // depth of one still needs a one-bit pointer
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PtrW-1:0]  wptr;
  logic [PtrW-1:0]  rptr;
  logic [CntW-1:0]  count;
  logic             empty;
  logic             full;
  logic             bypass;
  logic             push;
  logic             pop;

  assign empty = (count == '0);
  assign full  = (count == CntW'(Depth));

  // consumer takes the incoming word straight through, nothing stored
  assign bypass = Pass && empty && wvalid_i && rready_i;

  assign push = wvalid_i && !full && !bypass;
  assign pop  = rready_i && !empty;

  assign wready_o = !full;
  assign rvalid_o = !empty || (Pass && wvalid_i);
  // head of storage unless pass-through is active
  assign rdata_o  = (Pass && empty) ? wdata_i : mem[rptr];

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wptr] <= wdata_i;
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        // wrap at Depth, not at the pointer width
        wptr <= (wptr == PtrW'(Depth - 1)) ? '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (rptr == PtrW'(Depth - 1)) ? '0 : rptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // producers must check wready, the SRAM read return has no back-pressure
  a_no_push_full : assert property (@(posedge clock) disable iff (!rst_n_i)
    wvalid_i |-> !full);

  // consumers only pop what is offered
  a_no_pop_empty : assert property (@(posedge clock) disable iff (!rst_n_i)
    rready_i |-> rvalid_o);

endmodule

`default_nettype wire

// File: design/tlul_req_check.sv
// combinational A-channel filter; flags are only meaningful while a_valid_i is high
`timescale 1ns/1ps
`default_nettype none

module tlul_req_check (
  input  wire logic                          a_valid_i,
  input  wire tlul_pkg::tl_a_op_e            a_opcode_i,
  input  wire logic [tlul_pkg::TL_SZW-1:0]   a_size_i,
  input  wire logic [tlul_pkg::TL_DBW-1:0]   a_mask_i,
  output logic                               req_err_o,
  output logic                               req_is_read_o
);

  import tlul_pkg::*;

  logic is_write;
  logic op_err;
  logic size_err;
  logic full_mask_err;
  logic partial_err;

  assign is_write = (a_opcode_i == PutFullData) || (a_opcode_i == PutPartialData);

  // anything outside Get / PutFullData / PutPartialData
  assign op_err = !(a_opcode_i inside {Get, PutFullData, PutPartialData});

  // bus word is 4 bytes, size 3 asks for 8
  assign size_err = (a_size_i > 2'd2);

  // full put must enable every byte
  assign full_mask_err = (a_opcode_i == PutFullData) && (a_mask_i != '1);

  // without byte access only full-word writes are legal
  assign partial_err = !BYTE_ACCESS && is_write &&
                       ((a_mask_i != '1) || (a_size_i != 2'd2));

  assign req_err_o     = a_valid_i && (op_err || size_err || full_mask_err || partial_err);
  assign req_is_read_o = (a_opcode_i == Get);

  // an X here would steer both the SRAM strobe and the error response
  always_comb begin
    if (a_valid_i) begin
      a_err_known : assert (!$isunknown(req_err_o));
    end
  end

endmodule

`default_nettype wire

// File: design/tlul_sram_adapter.sv
// TL-UL to 64-bit SRAM bridge; no base address so addresses alias, no read error path
`timescale 1ns/1ps
`default_nettype none

module tlul_sram_adapter (
  input  wire logic                           clock,
  input  wire logic                           rst_n_i,

  // A channel
  input  wire logic                           a_valid_i,
  output logic                                a_ready_o,
  input  wire tlul_pkg::tl_a_op_e             a_opcode_i,
  input  wire logic [tlul_pkg::TL_SZW-1:0]    a_size_i,
  input  wire logic [tlul_pkg::TL_AIW-1:0]    a_source_i,
  input  wire logic [tlul_pkg::TL_AW-1:0]     a_address_i,
  input  wire logic [tlul_pkg::TL_DBW-1:0]    a_mask_i,
  input  wire logic [tlul_pkg::TL_DW-1:0]     a_data_i,

  // D channel
  output logic                                d_valid_o,
  input  wire logic                           d_ready_i,
  output tlul_pkg::tl_d_op_e                  d_opcode_o,
  output logic      [tlul_pkg::TL_SZW-1:0]    d_size_o,
  output logic      [tlul_pkg::TL_AIW-1:0]    d_source_o,
  output logic      [tlul_pkg::TL_DW-1:0]     d_data_o,
  output logic                                d_error_o,

  // from the request checker
  input  wire logic                           req_err_i,
  input  wire logic                           req_is_read_i,

  // SRAM strobes
  output logic                                req_o,
  output logic                                we_o,
  output logic      [tlul_pkg::SRAM_AW-1:0]   addr_o,
  output logic      [tlul_pkg::SRAM_DW-1:0]   wdata_o,
  output logic      [tlul_pkg::SRAM_DW-1:0]   wmask_o,
  input  wire logic                           gnt_i,
  input  wire logic                           rvalid_i,
  input  wire logic [tlul_pkg::SRAM_DW-1:0]   rdata_i
);

  import tlul_pkg::*;

  logic                   a_ack;
  logic                   d_ack;
  logic                   sram_ack;
  logic [LANE_W-1:0]      a_lane;

  logic                   reqfifo_wready;
  logic                   reqfifo_rvalid;
  logic                   reqfifo_rready;
  logic [REQ_FIFO_W-1:0]  reqfifo_wdata;
  logic [REQ_FIFO_W-1:0]  reqfifo_rdata;

  logic                   lanefifo_wvalid;
  logic                   lanefifo_wready;
  logic                   lanefifo_rvalid;
  logic [LANE_FIFO_W-1:0] lanefifo_wdata;
  logic [LANE_FIFO_W-1:0] lanefifo_rdata;

  logic                   rspfifo_wvalid;
  logic                   rspfifo_rvalid;
  logic                   rspfifo_rready;
  logic [RSP_FIFO_W-1:0]  rspfifo_wdata;
  logic [RSP_FIFO_W-1:0]  rspfifo_rdata;

  // head of the request queue, split back into fields
  req_op_e                head_op;
  logic                   head_err;
  logic [LANE_W-1:0]      head_lane;
  logic [TL_DBW-1:0]      head_mask;
  logic [TL_DW-1:0]       rd_word;

  assign a_ack    = a_valid_i && a_ready_o;
  assign d_ack    = d_valid_o && d_ready_i;
  assign sram_ack = req_o && gnt_i;

  // needs queue room, plus a grant unless the request is dropped as an error
  assign a_ready_o = (gnt_i || req_err_i) && reqfifo_wready && lanefifo_wready;

  // flagged requests never touch memory
  assign req_o  = a_valid_i && reqfifo_wready && lanefifo_wready && !req_err_i;
  assign we_o   = a_valid_i && (a_opcode_i inside {PutFullData, PutPartialData});
  assign addr_o = a_address_i[SRAM_BYTE_LSB +: SRAM_AW];

  // address bit 2 picks the 32-bit half
  assign a_lane = a_address_i[SRAM_BYTE_LSB-LANE_W +: LANE_W];

  // byte mask widened to bits, data only in enabled bytes
  always_comb begin
    wmask_o = '0;
    wdata_o = '0;
    for (int i = 0; i < TL_DBW; i++) begin
      wmask_o[TL_DW*a_lane + 8*i +: 8] = {8{a_mask_i[i]}};
      wdata_o[TL_DW*a_lane + 8*i +: 8] = a_mask_i[i] ? a_data_i[8*i +: 8] : 8'h00;
    end
  end

  // every accepted request is queued, errors included
  assign reqfifo_wdata  = {(req_is_read_i ? OpRead : OpWrite), req_err_i, a_size_i, a_source_i};
  assign reqfifo_rready = d_ack;

  assign head_op  = req_op_e'(reqfifo_rdata[REQ_FIFO_W-1]);
  assign head_err = reqfifo_rdata[REQ_FIFO_W-2];

  // lane and mask for reads still waiting on memory
  assign lanefifo_wvalid = sram_ack && !we_o;
  assign lanefifo_wdata  = {a_mask_i, a_lane};
  assign head_mask       = lanefifo_rdata[LANE_W +: TL_DBW];
  assign head_lane       = lanefifo_rdata[LANE_W-1:0];

  // read return: pick the half, zero the bytes outside the mask
  assign rd_word = rdata_i[TL_DW*head_lane +: TL_DW];
  always_comb begin
    rspfifo_wdata = '0;
    for (int i = 0; i < TL_DBW; i++) begin
      rspfifo_wdata[8*i +: 8] = head_mask[i] ? rd_word[8*i +: 8] : 8'h00;
    end
  end

  assign rspfifo_wvalid = rvalid_i && lanefifo_rvalid;
  // only a clean read at the head consumes return data
  assign rspfifo_rready = d_ack && (head_op == OpRead) && !head_err;

  // writes and errors answer at once, reads wait for data
  always_comb begin
    d_valid_o = 1'b0;
    if (reqfifo_rvalid) begin
      if (head_err || head_op == OpWrite) begin
        d_valid_o = 1'b1;
      end else begin
        d_valid_o = rspfifo_rvalid;
      end
    end
  end

  assign d_opcode_o = (head_op == OpRead) ? AccessAckData : AccessAck;
  assign d_size_o   = reqfifo_rdata[TL_AIW +: TL_SZW];
  assign d_source_o = reqfifo_rdata[TL_AIW-1:0];
  assign d_error_o  = d_valid_o && head_err;
  // errored Get returns zero, not data of a later read
  assign d_data_o   = (d_valid_o && head_op == OpRead && !head_err) ? rspfifo_rdata : '0;

  // request queue, popped on the D handshake
  fifo_sync #(
    .Width (REQ_FIFO_W),
    .Depth (OUTSTANDING),
    .Pass  (1'b0)
  ) u_reqfifo (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .wvalid_i (a_ack),
    .wready_o (reqfifo_wready),
    .wdata_i  (reqfifo_wdata),
    .rvalid_o (reqfifo_rvalid),
    .rready_i (reqfifo_rready),
    .rdata_o  (reqfifo_rdata)
  );

  // lane queue, popped when read data returns
  fifo_sync #(
    .Width (LANE_FIFO_W),
    .Depth (OUTSTANDING),
    .Pass  (1'b0)
  ) u_lanefifo (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .wvalid_i (lanefifo_wvalid),
    .wready_o (lanefifo_wready),
    .wdata_i  (lanefifo_wdata),
    .rvalid_o (lanefifo_rvalid),
    .rready_i (rvalid_i),
    .rdata_o  (lanefifo_rdata)
  );

  // holds read data while D is stalled, memory cannot be back-pressured
  fifo_sync #(
    .Width (RSP_FIFO_W),
    .Depth (OUTSTANDING),
    .Pass  (1'b1)
  ) u_rspfifo (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .wvalid_i (rspfifo_wvalid),
    .wready_o (),
    .wdata_i  (rspfifo_wdata),
    .rvalid_o (rspfifo_rvalid),
    .rready_i (rspfifo_rready),
    .rdata_o  (rspfifo_rdata)
  );

  // response stays offered until the host takes it
  a_d_valid_hold : assert property (@(posedge clock) disable iff (!rst_n_i)
    d_valid_o && !d_ready_i |=> d_valid_o);

endmodule

`default_nettype wire

// File: design/sram_1p.sv
// behavioral single-port RAM; always grants, contents are not reset
`timescale 1ns/1ps
`default_nettype none

module sram_1p (
  input  wire logic                          clock,
  input  wire logic                          rst_n_i,
  input  wire logic                          req_i,
  input  wire logic                          we_i,
  input  wire logic [tlul_pkg::SRAM_AW-1:0]  addr_i,
  input  wire logic [tlul_pkg::SRAM_DW-1:0]  wdata_i,
  input  wire logic [tlul_pkg::SRAM_DW-1:0]  wmask_i,
  output logic                               gnt_o,
  output logic                               rvalid_o,
  output logic      [tlul_pkg::SRAM_DW-1:0]  rdata_o
);

  import tlul_pkg::*;

  logic [SRAM_DW-1:0] mem [SRAM_WORDS];
  logic               rd_req;

  // no arbitration, every request is granted
  assign gnt_o  = req_i;
  assign rd_req = req_i && gnt_o && !we_i;

  // bit-masked write, read data registered
  always_ff @(posedge clock) begin
    if (req_i && gnt_o) begin
      if (we_i) begin
        mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_req;
    end
  end

  // an unknown strobe or address would corrupt the array unnoticed
  a_req_known : assert property (@(posedge clock) disable iff (!rst_n_i)
    req_i |-> !$isunknown({we_i, addr_i}));

endmodule

`default_nettype wire

// File: design/tlul_sram_top.sv
// TL-UL device with 8 KiB of SRAM; addresses alias above the memory size
`timescale 1ns/1ps
`default_nettype none

module tlul_sram_top (
  input  wire logic                          clock,
  input  wire logic                          rst_n_i,

  // A channel
  input  wire logic                          a_valid_i,
  output logic                               a_ready_o,
  input  wire tlul_pkg::tl_a_op_e            a_opcode_i,
  input  wire logic [tlul_pkg::TL_SZW-1:0]   a_size_i,
  input  wire logic [tlul_pkg::TL_AIW-1:0]   a_source_i,
  input  wire logic [tlul_pkg::TL_AW-1:0]    a_address_i,
  input  wire logic [tlul_pkg::TL_DBW-1:0]   a_mask_i,
  input  wire logic [tlul_pkg::TL_DW-1:0]    a_data_i,

  // D channel
  output logic                               d_valid_o,
  input  wire logic                          d_ready_i,
  output tlul_pkg::tl_d_op_e                 d_opcode_o,
  output logic      [tlul_pkg::TL_SZW-1:0]   d_size_o,
  output logic      [tlul_pkg::TL_AIW-1:0]   d_source_o,
  output logic      [tlul_pkg::TL_DW-1:0]    d_data_o,
  output logic                               d_error_o
);

  import tlul_pkg::*;

  logic               req_err;
  logic               req_is_read;

  // SRAM side strobes
  logic               sram_req;
  logic               sram_we;
  logic [SRAM_AW-1:0] sram_addr;
  logic [SRAM_DW-1:0] sram_wdata;
  logic [SRAM_DW-1:0] sram_wmask;
  logic               sram_gnt;
  logic               sram_rvalid;
  logic [SRAM_DW-1:0] sram_rdata;

  tlul_req_check u_req_check (
    .a_valid_i     (a_valid_i),
    .a_opcode_i    (a_opcode_i),
    .a_size_i      (a_size_i),
    .a_mask_i      (a_mask_i),
    .req_err_o     (req_err),
    .req_is_read_o (req_is_read)
  );

  tlul_sram_adapter u_adapter (
    .clock         (clock),
    .rst_n_i       (rst_n_i),
    .a_valid_i     (a_valid_i),
    .a_ready_o     (a_ready_o),
    .a_opcode_i    (a_opcode_i),
    .a_size_i      (a_size_i),
    .a_source_i    (a_source_i),
    .a_address_i   (a_address_i),
    .a_mask_i      (a_mask_i),
    .a_data_i      (a_data_i),
    .d_valid_o     (d_valid_o),
    .d_ready_i     (d_ready_i),
    .d_opcode_o    (d_opcode_o),
    .d_size_o      (d_size_o),
    .d_source_o    (d_source_o),
    .d_data_o      (d_data_o),
    .d_error_o     (d_error_o),
    .req_err_i     (req_err),
    .req_is_read_i (req_is_read),
    .req_o         (sram_req),
    .we_o          (sram_we),
    .addr_o        (sram_addr),
    .wdata_o       (sram_wdata),
    .wmask_o       (sram_wmask),
    .gnt_i         (sram_gnt),
    .rvalid_i      (sram_rvalid),
    .rdata_i       (sram_rdata)
  );

  sram_1p u_sram (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .req_i    (sram_req),
    .we_i     (sram_we),
    .addr_i   (sram_addr),
    .wdata_i  (sram_wdata),
    .wmask_i  (sram_wmask),
    .gnt_o    (sram_gnt),
    .rvalid_o (sram_rvalid),
    .rdata_o  (sram_rdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// free-running testbench clock; reset starts low at time zero and is released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HalfPeriod = 4,
  parameter int RstCycles  = 2
) (
  output logic clock_o,
  output logic rst_n_o
);

  initial begin
    clock_o = 1'b0;
    forever #HalfPeriod clock_o = ~clock_o;
  end

  // hold reset for RstCycles rising edges, release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RstCycles) @(posedge clock_o);
    @(negedge clock_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_tlul_sram.sv
// directed TL-UL testbench; reads only touch words written before, since SRAM contents start unknown
`timescale 1ns/1ps
`default_nettype none

module tb_tlul_sram;

  import tlul_pkg::*;

  localparam int Timeout  = 100;
  // 8 KiB seen as 32-bit words
  localparam int RefAw    = SRAM_AW + LANE_W;
  localparam int RefWords = 1 << RefAw;
  localparam int RandOps  = 40;

  logic              clock;
  logic              rst_n;
  logic              a_valid;
  logic              a_ready;
  tl_a_op_e          a_opcode;
  logic [TL_SZW-1:0] a_size;
  logic [TL_AIW-1:0] a_source;
  logic [TL_AW-1:0]  a_address;
  logic [TL_DBW-1:0] a_mask;
  logic [TL_DW-1:0]  a_data;
  logic              d_valid;
  logic              d_ready;
  tl_d_op_e          d_opcode;
  logic [TL_SZW-1:0] d_size;
  logic [TL_AIW-1:0] d_source;
  logic [TL_DW-1:0]  d_data;
  logic              d_error;

  // reference memory, indexed by address modulo the SRAM size
  logic [TL_DW-1:0]  ref_mem [RefWords];

  // expected responses in request order
  tl_d_op_e          exp_op_q [$];
  logic              exp_err_q [$];
  logic [TL_SZW-1:0] exp_size_q [$];
  logic [TL_AIW-1:0] exp_src_q [$];
  logic [TL_DW-1:0]  exp_data_q [$];

  int seed          = 32'h6ce86858;
  int err_count     = 0;
  int timeout_count = 0;

  tb_clk_gen u_clk_gen (
    .clock_o (clock),
    .rst_n_o (rst_n)
  );

  tlul_sram_top dut_i (
    .clock       (clock),
    .rst_n_i     (rst_n),
    .a_valid_i   (a_valid),
    .a_ready_o   (a_ready),
    .a_opcode_i  (a_opcode),
    .a_size_i    (a_size),
    .a_source_i  (a_source),
    .a_address_i (a_address),
    .a_mask_i    (a_mask),
    .a_data_i    (a_data),
    .d_valid_o   (d_valid),
    .d_ready_i   (d_ready),
    .d_opcode_o  (d_opcode),
    .d_size_o    (d_size),
    .d_source_o  (d_source),
    .d_data_o    (d_data),
    .d_error_o   (d_error)
  );

  task automatic check_data(input string name, input logic [TL_DW-1:0] exp,
                            input logic [TL_DW-1:0] act);
    if (act !== exp) begin
      err_count++;
      $display("Fail at %0t: %s expected %08h, got %08h", $time, name, exp, act);
    end
  endtask

  task automatic check_op(input string name, input tl_d_op_e exp, input tl_d_op_e act);
    if (act !== exp) begin
      err_count++;
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  // single-bit flags such as d_error_o or the handshake signals
  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_source(input string name, input logic [TL_AIW-1:0] exp,
                              input logic [TL_AIW-1:0] act);
    if (act !== exp) begin
      err_count++;
      $display("Fail at %0t: %s expected %02h, got %02h", $time, name, exp, act);
    end
  endtask

  task automatic check_size(input string name, input logic [TL_SZW-1:0] exp,
                            input logic [TL_SZW-1:0] act);
    if (act !== exp) begin
      err_count++;
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  // TL-UL rules: only Get and the two puts, at most 4 bytes, a full put enables every byte
  function automatic void predict_response(input tl_a_op_e op, input logic [TL_SZW-1:0] size,
                                           input logic [TL_AIW-1:0] src,
                                           input logic [TL_AW-1:0] addr,
                                           input logic [TL_DBW-1:0] mask,
                                           input logic [TL_DW-1:0] data);
    logic             err;
    logic [TL_DW-1:0] word;
    int               idx;
    err  = !(op == PutFullData || op == PutPartialData || op == Get) || (size == 2'd3) ||
           (op == PutFullData && mask != 4'hf);
    idx  = int'(addr[2 +: RefAw]);
    word = '0;
    if (op == Get) begin
      // bytes outside the mask read as zero
      for (int i = 0; i < TL_DBW; i++) begin
        if (!err && mask[i]) begin
          word[8*i +: 8] = ref_mem[idx][8*i +: 8];
        end
      end
      exp_op_q.push_back(AccessAckData);
    end else begin
      for (int i = 0; i < TL_DBW; i++) begin
        if (!err && mask[i]) begin
          ref_mem[idx][8*i +: 8] = data[8*i +: 8];
        end
      end
      exp_op_q.push_back(AccessAck);
    end
    exp_err_q.push_back(err);
    exp_size_q.push_back(size);
    exp_src_q.push_back(src);
    exp_data_q.push_back(word);
  endfunction

  // starts and ends on a falling edge, fields stay put until the handshake
  task automatic drive_request(input tl_a_op_e op, input logic [TL_SZW-1:0] size,
                               input logic [TL_AIW-1:0] src, input logic [TL_AW-1:0] addr,
                               input logic [TL_DBW-1:0] mask, input logic [TL_DW-1:0] data);
    int waited;
    bit done;
    a_valid   = 1'b1;
    a_opcode  = op;
    a_size    = size;
    a_source  = src;
    a_address = addr;
    a_mask    = mask;
    a_data    = data;
    waited    = 0;
    done      = 1'b0;
    while (!done && waited < Timeout) begin
      #1;
      // ready is settled here, the transfer happens at the coming rising edge
      if (a_ready) begin
        done = 1'b1;
        predict_response(op, size, src, addr, mask, data);
      end
      @(negedge clock);
      waited++;
    end
    a_valid = 1'b0;
    if (!done) begin
      timeout_count++;
      $display("timeout at %0t: A request from source %02h was never accepted", $time, src);
    end
  endtask

  task automatic tl_put(input tl_a_op_e op, input logic [TL_SZW-1:0] size,
                        input logic [TL_AIW-1:0] src, input logic [TL_AW-1:0] addr,
                        input logic [TL_DBW-1:0] mask, input logic [TL_DW-1:0] data);
    drive_request(op, size, src, addr, mask, data);
  endtask

  task automatic tl_get(input logic [TL_SZW-1:0] size, input logic [TL_AIW-1:0] src,
                        input logic [TL_AW-1:0] addr, input logic [TL_DBW-1:0] mask);
    drive_request(Get, size, src, addr, mask, '0);
  endtask

  // holds d_ready low for stall cycles, then takes one response and checks it
  task automatic tl_expect_rsp(input int stall);
    int                waited;
    bit                got;
    tl_d_op_e          e_op;
    logic              e_err;
    logic [TL_SZW-1:0] e_size;
    logic [TL_AIW-1:0] e_src;
    logic [TL_DW-1:0]  e_data;
    d_ready = 1'b0;
    repeat (stall) @(negedge clock);
    d_ready = 1'b1;
    waited  = 0;
    got     = 1'b0;
    while (!got && waited < Timeout) begin
      #1;
      if (d_valid) begin
        got = 1'b1;
        if (exp_op_q.size() == 0) begin
          err_count++;
          $display("error at %0t: D response with no request outstanding", $time);
        end else begin
          e_op   = exp_op_q.pop_front();
          e_err  = exp_err_q.pop_front();
          e_size = exp_size_q.pop_front();
          e_src  = exp_src_q.pop_front();
          e_data = exp_data_q.pop_front();
          check_op("d_opcode_o", e_op, d_opcode);
          check_err("d_error_o", e_err, d_error);
          check_size("d_size_o", e_size, d_size);
          check_source("d_source_o", e_src, d_source);
          if (e_op == AccessAckData) begin
            check_data("d_data_o", e_data, d_data);
          end
        end
      end
      @(negedge clock);
      waited++;
    end
    d_ready = 1'b0;
    if (!got) begin
      timeout_count++;
      $display("timeout at %0t: no D response arrived", $time);
    end
  endtask

  task automatic reset_values();
    #1;
    check_err("d_valid_o", 1'b0, d_valid);
    @(negedge clock);
    // ready only reflects queue room once a request is offered
    a_valid   = 1'b1;
    a_opcode  = PutFullData;
    a_size    = 2'd2;
    a_mask    = 4'hf;
    a_address = '0;
    #1;
    check_err("a_ready_o", 1'b1, a_ready);
    // withdrawn before any rising edge, so nothing transfers
    a_valid = 1'b0;
    @(negedge clock);
  endtask

  task automatic full_word_rw();
    logic [TL_AW-1:0] addr;
    // both lanes of four words, upper address bits vary to exercise aliasing
    for (int i = 0; i < 8; i++) begin
      addr = 32'h0001_2000 * (i / 2) + 32'd40 * (i / 2) + 32'd4 * (i % 2);
      tl_put(PutFullData, 2'd2, 8'(8'h10 + i), addr, 4'hf, $random(seed));
      tl_expect_rsp(0);
    end
    for (int i = 0; i < 8; i++) begin
      addr = 32'h0001_2000 * (i / 2) + 32'd40 * (i / 2) + 32'd4 * (i % 2);
      tl_get(2'd2, 8'(8'h20 + i), addr, 4'hf);
      tl_expect_rsp(0);
    end
  endtask

  task automatic partial_writes();
    logic [TL_DBW-1:0] masks [4];
    masks = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    tl_put(PutFullData, 2'd2, 8'h30, 32'h200, 4'hf, 32'h1122_3344);
    tl_expect_rsp(0);
    tl_put(PutFullData, 2'd2, 8'h31, 32'h204, 4'hf, 32'h5566_7788);
    tl_expect_rsp(0);
    for (int i = 0; i < 4; i++) begin
      tl_put(PutPartialData, 2'd2, 8'(8'h32 + i), 32'h200 + 4 * (i % 2), masks[i],
             $random(seed));
      tl_expect_rsp(0);
    end
    tl_get(2'd2, 8'h38, 32'h200, 4'hf);
    tl_expect_rsp(0);
    tl_get(2'd2, 8'h39, 32'h204, 4'hf);
    tl_expect_rsp(0);
    // half-word read, unmasked bytes come back as zero
    tl_get(2'd1, 8'h3a, 32'h200, 4'b0101);
    tl_expect_rsp(0);
  endtask

  task automatic error_requests();
    tl_put(PutFullData, 2'd2, 8'h40, 32'h300, 4'hf, 32'hcafe_f00d);
    tl_expect_rsp(0);
    // opcode 2 is not one of the three supported
    tl_put(tl_a_op_e'(3'h2), 2'd2, 8'h41, 32'h300, 4'hf, 32'hdead_0001);
    tl_expect_rsp(0);
    tl_put(PutPartialData, 2'd3, 8'h42, 32'h300, 4'hf, 32'hdead_0002);
    tl_expect_rsp(0);
    tl_put(PutFullData, 2'd2, 8'h43, 32'h300, 4'h3, 32'hdead_0003);
    tl_expect_rsp(0);
    tl_get(2'd3, 8'h44, 32'h300, 4'hf);
    tl_expect_rsp(0);
    // memory must still hold the first write
    tl_get(2'd2, 8'h45, 32'h300, 4'hf);
    tl_expect_rsp(0);
  endtask

  task automatic stalled_responses();
    tl_put(PutFullData, 2'd2, 8'h50, 32'h400, 4'hf, $random(seed));
    tl_get(2'd2, 8'h51, 32'h400, 4'hf);
    // third request finds both queue slots taken
    a_valid   = 1'b1;
    a_opcode  = Get;
    a_size    = 2'd2;
    a_source  = 8'h52;
    a_address = 32'h400;
    a_mask    = 4'hc;
    repeat (3) begin
      #1;
      check_err("a_ready_o", 1'b0, a_ready);
      @(negedge clock);
    end
    fork
      tl_get(2'd2, 8'h52, 32'h400, 4'hc);
      begin
        repeat (3) tl_expect_rsp(0);
      end
    join
  endtask

  task automatic random_traffic();
    logic              rnd_read [RandOps];
    logic [TL_DBW-1:0] rnd_mask [RandOps];
    logic [TL_AIW-1:0] rnd_src [RandOps];
    logic [TL_AW-1:0]  rnd_addr [RandOps];
    logic [TL_DW-1:0]  rnd_data [RandOps];
    int                rnd_stall [RandOps];
    logic [31:0]       r;
    // fill the 16-word window so that every read sees known data
    for (int w = 0; w < 16; w++) begin
      tl_put(PutFullData, 2'd2, 8'(w), 32'(4 * w), 4'hf, $random(seed));
      tl_expect_rsp(0);
    end
    // stimulus drawn up front, so its order never depends on the two processes
    for (int i = 0; i < RandOps; i++) begin
      r            = $random(seed);
      rnd_read[i]  = r[0];
      rnd_mask[i]  = r[7:4];
      rnd_src[i]   = r[15:8];
      rnd_stall[i] = int'(r[17:16]);
      // upper bits alias, bits 5:2 pick a word in the window
      rnd_addr[i]  = $random(seed) & 32'hffff_e03c;
      rnd_data[i]  = $random(seed);
    end
    fork
      begin
        for (int i = 0; i < RandOps; i++) begin
          if (rnd_read[i]) begin
            tl_get(2'd2, rnd_src[i], rnd_addr[i], rnd_mask[i]);
          end else if (rnd_mask[i] == 4'hf) begin
            tl_put(PutFullData, 2'd2, rnd_src[i], rnd_addr[i], 4'hf, rnd_data[i]);
          end else begin
            tl_put(PutPartialData, 2'd2, rnd_src[i], rnd_addr[i], rnd_mask[i], rnd_data[i]);
          end
        end
      end
      begin
        for (int i = 0; i < RandOps; i++) begin
          tl_expect_rsp(rnd_stall[i]);
        end
      end
    join
  endtask

  initial begin
    int waited;
    a_valid   = 1'b0;
    a_opcode  = Get;
    a_size    = '0;
    a_source  = '0;
    a_address = '0;
    a_mask    = '0;
    a_data    = '0;
    d_ready   = 1'b0;
    waited    = 0;
    while (rst_n !== 1'b1 && waited < Timeout) begin
      @(posedge clock);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      timeout_count++;
      $display("timeout: reset was never released");
    end
    @(negedge clock);
    reset_values();
    full_word_rw();
    partial_writes();
    error_requests();
    stalled_responses();
    random_traffic();
    if (exp_op_q.size() != 0) begin
      err_count++;
      $display("error: %0d responses never arrived", exp_op_q.size());
    end
    $display("checks failed: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
design/tlul_pkg.sv
design/fifo_sync.sv
design/tlul_req_check.sv
design/tlul_sram_adapter.sv
design/sram_1p.sv
design/tlul_sram_top.sv
dv/tb_clk_gen.sv
dv/tb_tlul_sram.sv

// File: run_sim.sh
#!/bin/sh
# build the TL-UL SRAM testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_tlul_sram \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_tlul_sram)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
